/* dv/tb_vector_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vector_unit_defs.svh"

module tb_vector_unit;
	import pkg_tpu::*;

	localparam int ACK_TIMEOUT	= 40;	// Cycles per bus access
	localparam int IDLE_TIMEOUT	= 40;	// STATUS polls

	logic		clock;
	logic		reset;
	logic		wb_cyc;
	logic		wb_stb;
	logic		wb_we;
	logic [7:0]	wb_adr;
	data_t		wb_dat_w;
	data_t		wb_dat_r;
	logic		wb_ack;

	data_t		model_regs [`NUM_LANE][`NUM_REG];
	lane_t		model_zero;			// Zero flag of the last write per lane
	logic		model_commit;
	data_t		model_scalar;
	string		test_name;
	reg_idx_t	dst_sel;
	id_t		tid;

	vector_unit_top uut (
		.clock		(clock),
		.reset		(reset),
		.wb_cyc		(wb_cyc),
		.wb_stb		(wb_stb),
		.wb_we		(wb_we),
		.wb_adr		(wb_adr),
		.wb_dat_w	(wb_dat_w),
		.wb_dat_r	(wb_dat_r),
		.wb_ack		(wb_ack)
	);

	always #50 clock = ~clock;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// One Wishbone classic cycle held until ack
	task automatic bus_cycle(input logic we, input logic [7:0] adr, input data_t wdata,
			output data_t rdata);
		int cycles;
		cycles = 0;
		@(negedge clock);
		wb_cyc		= 1'b1;
		wb_stb		= 1'b1;
		wb_we		= we;
		wb_adr		= adr;
		wb_dat_w	= wdata;
		while (!wb_ack && cycles < ACK_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		assert (wb_ack) else
			fail_run($sformatf("%s: bus access to 0x%02h was never acknowledged",
				test_name, adr));
		rdata	= wb_dat_r;
		wb_cyc	= 1'b0;
		wb_stb	= 1'b0;
		wb_we	= 1'b0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input data_t data);
		data_t unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [7:0] adr, output data_t data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	function automatic data_t cmd_word(v_opcode_t op, reg_idx_t dst, reg_idx_t s1,
			reg_idx_t s2, lane_t mask, id_t thread);
		data_t w;
		w = '0;
		w[CMD_OP_LSB +: 4]		= op;
		w[CMD_DST_LSB +: 4]		= {1'b0, dst};
		w[CMD_SRC1_LSB +: 4]	= {1'b0, s1};
		w[CMD_SRC2_LSB +: 4]	= {1'b0, s2};
		w[CMD_MASK_LSB +: 4]	= mask;
		w[CMD_TID_LSB +: 8]		= thread;
		return w;
	endfunction

	// Expected result of one enabled lane
	function automatic data_t exec_model(v_opcode_t op, data_t a, data_t b, data_t next_a,
			data_t scalar, id_t thread, int lane);
		data_t r;
		case (op)
			V_ADD:	r = a + b;
			V_SUB:	r = a - b;
			V_AND:	r = a & b;
			V_OR:	r = a | b;
			V_XOR:	r = a ^ b;
			V_MUL:	r = a * b;			// Low 32 bits kept
			V_MOVS:	r = scalar;
			V_LID:	r = data_t'(thread) * data_t'(`NUM_LANE) + data_t'(lane);
			V_ROT:	r = next_a;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic issue_cmd(input v_opcode_t op, input reg_idx_t dst, input reg_idx_t s1,
			input reg_idx_t s2, input lane_t mask, input id_t thread);
		data_t src1_pre [`NUM_LANE];
		data_t res;
		wb_write(8'(REG_CMD), cmd_word(op, dst, s1, s2, mask, thread));
		for (int l = 0; l < `NUM_LANE; l++)
			src1_pre[l] = model_regs[l][s1];	// Rotation sees old values
		for (int l = 0; l < `NUM_LANE; l++) begin
			if (mask[l] && op != V_NOP) begin
				res = exec_model(op, model_regs[l][s1], model_regs[l][s2],
					src1_pre[(l + 1) % `NUM_LANE], model_scalar, thread, l);
				model_regs[l][dst]	= res;
				model_zero[l]		= (res == '0);
			end
		end
		model_commit = (op != V_NOP) || (mask == '0);
	endtask

	task automatic random_cmd(input lane_t mask);
		issue_cmd(v_opcode_t'(4'($urandom_range(9, 1))), reg_idx_t'($urandom),
			reg_idx_t'($urandom), reg_idx_t'($urandom), mask, id_t'($urandom));
	endtask

	task automatic set_scalar(input data_t value);
		wb_write(8'(REG_SCALAR), value);
		model_scalar = value;
	endtask

	task automatic wait_idle();
		data_t st;
		int polls;
		polls = 0;
		wb_read(8'(REG_STATUS), st);
		while (!st[ST_IDLE] && polls < IDLE_TIMEOUT) begin
			wb_read(8'(REG_STATUS), st);
			polls++;
		end
		assert (st[ST_IDLE]) else
			fail_run($sformatf("%s: vector unit never returned to idle", test_name));
	endtask

	task automatic check_lanes();
		data_t got;
		for (int l = 0; l < `NUM_LANE; l++) begin
			for (int r = 0; r < `NUM_REG; r++) begin
				wb_read(8'(REG_LANE_BASE + l * 8 + r), got);
				assert (got === model_regs[l][r]) else
					fail_run($sformatf("MISMATCH %s lane %0d reg %0d expected %08h actual %08h",
						test_name, l, r, model_regs[l][r], got));
			end
		end
	endtask

	task automatic check_status();
		data_t got;
		data_t exp_st;
		exp_st					= '0;		// FIFO level field stays 0
		exp_st[`NUM_LANE-1:0]	= model_zero;
		exp_st[ST_COMMIT]		= model_commit;
		exp_st[ST_IDLE]			= 1'b1;
		wb_read(8'(REG_STATUS), got);
		assert (got === exp_st) else
			fail_run($sformatf("MISMATCH %s status expected %08h actual %08h",
				test_name, exp_st, got));
	endtask

	initial begin
		clock		= 1'b0;
		reset		= 1'b1;
		wb_cyc		= 1'b0;
		wb_stb		= 1'b0;
		wb_we		= 1'b0;
		wb_adr		= '0;
		wb_dat_w	= '0;
		test_name	= "reset";
		void'($urandom(32'heafc129c));
		for (int l = 0; l < `NUM_LANE; l++)
			for (int r = 0; r < `NUM_REG; r++)
				model_regs[l][r] = '0;
		model_zero		= '0;
		model_commit	= 1'b0;
		model_scalar	= '0;
		repeat (3) @(negedge clock);
		reset = 1'b0;

		check_lanes();
		check_status();

		test_name = "alu";
		for (int r = 0; r < `NUM_REG; r++) begin
			for (int l = 0; l < `NUM_LANE; l++) begin
				set_scalar($urandom);
				issue_cmd(V_MOVS, reg_idx_t'(r), '0, '0, lane_t'(1 << l), '0);	// One lane each
			end
		end
		repeat (3) begin
			for (v_opcode_t op = V_ADD; op <= V_MUL; op = op.next())
				issue_cmd(op, reg_idx_t'($urandom), reg_idx_t'($urandom),
					reg_idx_t'($urandom), '1, '0);
		end
		wait_idle();
		check_lanes();
		check_status();

		test_name	= "lane_mask";
		dst_sel		= reg_idx_t'($urandom);
		random_cmd(4'b0110);
		issue_cmd(V_XOR, dst_sel, dst_sel, dst_sel, 4'b1001, '0);		// Zero in lanes 0 and 3
		wait_idle();
		check_lanes();
		check_status();
		issue_cmd(V_NOP, '0, '0, '0, 4'b0011, '0);		// Nothing commits
		wait_idle();
		check_status();

		test_name	= "lid_rot";
		tid			= id_t'($urandom);
		dst_sel		= reg_idx_t'($urandom);
		issue_cmd(V_LID, dst_sel, '0, '0, '1, tid);
		issue_cmd(V_ROT, reg_idx_t'($urandom), dst_sel, '0, '1, '0);
		issue_cmd(V_ROT, dst_sel, dst_sel, '0, 4'b1010, '0);		// In place on the odd lanes
		wait_idle();
		check_lanes();
		check_status();

		test_name = "burst";
		set_scalar($urandom);
		repeat (12)
			random_cmd(lane_t'($urandom));	// No idle wait in between
		wait_idle();
		check_lanes();
		check_status();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/cmd_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vector_unit_defs.svh"

module cmd_fifo (
	input	logic		clock,
	input	logic		reset,
	cmd_if.fifo_in		in,
	cmd_if.fifo_out		out
);
	import pkg_tpu::*;

	localparam int PW = $clog2(`FIFO_DEPTH);

	v_command_t		mem [`FIFO_DEPTH];
	logic [PW-1:0]	wr_ptr;
	logic [PW-1:0]	rd_ptr;
	level_t			count;
	logic			push;
	logic			pop;

	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	assign in.ready		= (count != level_t'(`FIFO_DEPTH));
	assign out.valid	= (count != '0);		// No bypass when empty
	assign out.cmd		= mem[rd_ptr];
	assign in.level		= count;
	assign out.level	= count;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= in.cmd;
	end

endmodule

`default_nettype wire

/* hdl/cmd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface cmd_if;
	import pkg_tpu::*;

	logic			valid;
	logic			ready;
	v_command_t		cmd;
	level_t			level;		// Entries held by the FIFO

	// Port side of the FIFO
	modport push	(output valid, output cmd, input ready, input level);
	modport fifo_in	(input valid, input cmd, output ready, output level);

	// Vector unit side of the FIFO
	modport fifo_out	(output valid, output cmd, output level, input ready);
	modport pop		(input valid, input cmd, input level, output ready);

endinterface

`default_nettype wire

/* hdl/lane_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vector_unit_defs.svh"

module lane_unit (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	logic [1:0]				lane_id,
	input	pkg_tpu::v_command_t	cmd,
	input	logic					fire,
	output	pkg_tpu::data_t			src1_out,
	input	pkg_tpu::data_t			neighbor_src1,
	input	pkg_tpu::reg_idx_t		rd_reg,
	output	pkg_tpu::data_t			rd_data,
	output	logic					commit,
	output	logic					zero
);
	import pkg_tpu::*;

	data_t	regs [`NUM_REG];
	data_t	src1;
	data_t	src2;
	data_t	result;
	logic	wr_en;

	assign src1		= regs[cmd.src1];
	assign src2		= regs[cmd.src2];
	assign src1_out	= src1;			// To the lane ring
	assign rd_data	= regs[rd_reg];	// Host read-back

	assign wr_en = fire && en && (cmd.opcode != V_NOP);

	always_comb begin
		case (cmd.opcode)
			V_ADD:	result = src1 + src2;
			V_SUB:	result = src1 - src2;
			V_AND:	result = src1 & src2;
			V_OR:	result = src1 | src2;
			V_XOR:	result = src1 ^ src2;
			V_MUL:	result = src1 * src2;	// Truncated to the low half
			V_MOVS:	result = cmd.scalar;
			V_LID:	result = data_t'(cmd.thread_id) * data_t'(`NUM_LANE) + data_t'(lane_id);
			V_ROT:	result = neighbor_src1;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < `NUM_REG; r++)
				regs[r] <= '0;
			commit	<= 1'b0;
			zero	<= 1'b0;
		end else begin
			commit <= wr_en;			// One-cycle pulse after the write
			if (wr_en) begin
				regs[cmd.dst]	<= result;
				zero			<= (result == '0);
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pkg_tpu.sv */
`default_nettype none

package pkg_tpu;

`include "vector_unit_defs.svh"

	typedef logic [`NUM_LANE-1:0]				lane_t;		// Enable, commit, status
	typedef logic [`DATA_W-1:0]				data_t;
	typedef logic [7:0]						id_t;		// SIMT thread ID
	typedef logic [`REG_AW-1:0]				reg_idx_t;
	typedef logic [$clog2(`FIFO_DEPTH+1)-1:0]	level_t;	// FIFO occupancy

	typedef enum logic [3:0] {
		V_NOP	= 4'd0,
		V_ADD	= 4'd1,
		V_SUB	= 4'd2,
		V_AND	= 4'd3,
		V_OR	= 4'd4,
		V_XOR	= 4'd5,
		V_MUL	= 4'd6,		// Low half of the product
		V_MOVS	= 4'd7,		// Scalar broadcast
		V_LID	= 4'd8,		// Global lane ID
		V_ROT	= 4'd9		// src1 of the next lane
	} v_opcode_t;

	typedef struct packed {
		v_opcode_t	opcode;
		reg_idx_t	dst;
		reg_idx_t	src1;
		reg_idx_t	src2;
		lane_t		mask;
		id_t		thread_id;
		data_t		scalar;
	} v_command_t;

	// CMD bus word, field offsets
	localparam int CMD_OP_LSB	= 0;
	localparam int CMD_DST_LSB	= 4;
	localparam int CMD_SRC1_LSB	= 8;
	localparam int CMD_SRC2_LSB	= 12;
	localparam int CMD_MASK_LSB	= 16;
	localparam int CMD_TID_LSB	= 20;

	// Register map
	localparam int REG_SCALAR		= 0;
	localparam int REG_CMD			= 1;
	localparam int REG_STATUS		= 2;
	localparam int REG_LANE_BASE	= 16;	// Plus lane*8 plus reg

	// STATUS word, above the lane zero flags
	localparam int ST_COMMIT	= 4;
	localparam int ST_IDLE		= 5;
	localparam int ST_LEVEL_LSB	= 8;

endpackage

`default_nettype wire

/* hdl/vector_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vector_unit_defs.svh"

module vector_unit (
	input	logic				clock,
	input	logic				reset,
	cmd_if.pop					cmd,
	input	logic [1:0]			rd_lane,
	input	pkg_tpu::reg_idx_t	rd_reg,
	output	pkg_tpu::data_t		rd_data,
	output	logic				commit_req,
	output	pkg_tpu::lane_t		status,
	output	logic				idle
);
	import pkg_tpu::*;

	v_command_t	cur;				// Command being executed
	logic		fire;
	logic		done;				// Commit stage of the last command
	lane_t		done_mask;
	lane_t		commit;
	data_t		src1_ring [`NUM_LANE];
	data_t		lane_rd [`NUM_LANE];

	assign cmd.ready	= 1'b1;		// Lanes finish in one cycle
	assign idle			= (cmd.level == '0) && !fire && !done;
	assign rd_data		= lane_rd[rd_lane];

	always_ff @(posedge clock) begin
		if (reset) begin
			fire		<= 1'b0;
			done		<= 1'b0;
			commit_req	<= 1'b0;
		end else begin
			fire <= cmd.valid && cmd.ready;
			done <= fire;
			// All enabled lanes committed, and only those
			if (done)
				commit_req <= &(~(done_mask ^ commit));
			else if (fire)
				commit_req <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (cmd.valid && cmd.ready)
			cur <= cmd.cmd;
		if (fire)
			done_mask <= cur.mask;
	end

	for (genvar i = 0; i < `NUM_LANE; i++) begin : g_lane
		lane_unit u_lane (
			.clock			(clock),
			.reset			(reset),
			.en				(cur.mask[i]),
			.lane_id		(2'(i)),
			.cmd			(cur),
			.fire			(fire),
			.src1_out		(src1_ring[i]),
			.neighbor_src1	(src1_ring[(i + 1) % `NUM_LANE]),	// Rotate by one lane
			.rd_reg			(rd_reg),
			.rd_data		(lane_rd[i]),
			.commit			(commit[i]),
			.zero			(status[i])
		);
	end

endmodule

`default_nettype wire

/* hdl/vector_unit_defs.svh */
`ifndef VECTOR_UNIT_DEFS_SVH
`define VECTOR_UNIT_DEFS_SVH

// Lane count, the width of lane_t and of the zero flags in STATUS
`define NUM_LANE	4

`define DATA_W		32		// Lane datapath width

`define NUM_REG		8		// Registers per lane
`define REG_AW		3		// Register index width

// Command FIFO entries, a power of two is not required
`define FIFO_DEPTH	4

`endif

/* hdl/vector_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vector_unit_top (
	input	logic				clock,
	input	logic				reset,
	input	logic				wb_cyc,
	input	logic				wb_stb,
	input	logic				wb_we,
	input	logic [7:0]			wb_adr,
	input	pkg_tpu::data_t		wb_dat_w,
	output	pkg_tpu::data_t		wb_dat_r,
	output	logic				wb_ack
);
	import pkg_tpu::*;

	cmd_if		push_if ();		// Port to FIFO
	cmd_if		pop_if ();		// FIFO to vector unit

	lane_t		status;
	logic		commit_req;
	logic		idle;
	logic [1:0]	rd_lane;
	reg_idx_t	rd_reg;
	data_t		rd_data;

	wb_cmd_port u_port (
		.clock		(clock),
		.reset		(reset),
		.wb_cyc		(wb_cyc),
		.wb_stb		(wb_stb),
		.wb_we		(wb_we),
		.wb_adr		(wb_adr),
		.wb_dat_w	(wb_dat_w),
		.wb_dat_r	(wb_dat_r),
		.wb_ack		(wb_ack),
		.cmd		(push_if.push),
		.status		(status),
		.commit_req	(commit_req),
		.idle		(idle),
		.rd_lane	(rd_lane),
		.rd_reg		(rd_reg),
		.rd_data	(rd_data)
	);

	cmd_fifo u_fifo (
		.clock	(clock),
		.reset	(reset),
		.in		(push_if.fifo_in),
		.out	(pop_if.fifo_out)
	);

	vector_unit u_vec (
		.clock		(clock),
		.reset		(reset),
		.cmd		(pop_if.pop),
		.rd_lane	(rd_lane),
		.rd_reg		(rd_reg),
		.rd_data	(rd_data),
		.commit_req	(commit_req),
		.status		(status),
		.idle		(idle)
	);

endmodule

`default_nettype wire

/* hdl/wb_cmd_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vector_unit_defs.svh"

module wb_cmd_port (
	input	logic				clock,
	input	logic				reset,
	input	logic				wb_cyc,
	input	logic				wb_stb,
	input	logic				wb_we,
	input	logic [7:0]			wb_adr,
	input	pkg_tpu::data_t		wb_dat_w,
	output	pkg_tpu::data_t		wb_dat_r,
	output	logic				wb_ack,
	cmd_if.push					cmd,
	input	pkg_tpu::lane_t		status,
	input	logic				commit_req,
	input	logic				idle,
	output	logic [1:0]			rd_lane,
	output	pkg_tpu::reg_idx_t	rd_reg,
	input	pkg_tpu::data_t		rd_data
);
	import pkg_tpu::*;

	data_t		scalar;			// Last value written to SCALAR
	data_t		rd_word;
	logic [7:0]	lane_off;
	logic		req;
	logic		is_cmd;
	logic		is_lane;
	v_command_t	cmd_word;

	assign req		= wb_cyc && wb_stb && !wb_ack;	// New cycle, not yet acked
	assign is_cmd	= wb_we && (wb_adr == 8'(REG_CMD));

	// Lane register window
	assign lane_off	= wb_adr - 8'(REG_LANE_BASE);
	assign is_lane	= (wb_adr >= 8'(REG_LANE_BASE)) &&
				  (wb_adr < 8'(REG_LANE_BASE + `NUM_LANE * 8));
	assign rd_lane	= lane_off[`REG_AW +: 2];
	assign rd_reg	= lane_off[`REG_AW-1:0];

	// CMD word plus the held scalar
	always_comb begin
		cmd_word.opcode		= v_opcode_t'(wb_dat_w[CMD_OP_LSB +: 4]);
		cmd_word.dst		= wb_dat_w[CMD_DST_LSB +: `REG_AW];
		cmd_word.src1		= wb_dat_w[CMD_SRC1_LSB +: `REG_AW];
		cmd_word.src2		= wb_dat_w[CMD_SRC2_LSB +: `REG_AW];
		cmd_word.mask		= wb_dat_w[CMD_MASK_LSB +: `NUM_LANE];
		cmd_word.thread_id	= wb_dat_w[CMD_TID_LSB +: 8];
		cmd_word.scalar		= scalar;
	end

	always_comb begin
		rd_word = '0;
		if (wb_adr == 8'(REG_STATUS)) begin
			rd_word[`NUM_LANE-1:0]					= status;
			rd_word[ST_COMMIT]						= commit_req;
			rd_word[ST_IDLE]						= idle;
			rd_word[ST_LEVEL_LSB +: $bits(level_t)]	= cmd.level;
		end else if (is_lane) begin
			rd_word = rd_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_ack		<= 1'b0;
			cmd.valid	<= 1'b0;
			scalar		<= '0;
		end else begin
			wb_ack <= 1'b0;
			if (cmd.valid && cmd.ready) begin	// FIFO took it, finish the cycle
				cmd.valid	<= 1'b0;
				wb_ack		<= 1'b1;
			end else if (req && is_cmd) begin
				cmd.valid	<= 1'b1;			// Held until the FIFO has room
			end else if (req) begin
				wb_ack <= 1'b1;
				if (wb_we && wb_adr == 8'(REG_SCALAR))
					scalar <= wb_dat_w;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req && is_cmd && !cmd.valid)
			cmd.cmd <= cmd_word;
		if (req && !wb_we)
			wb_dat_r <= rd_word;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the vector unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_vector_unit -Mdir obj_dir -f vector_unit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_vector_unit 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

/* vector_unit.f */
+incdir+hdl
hdl/pkg_tpu.sv
hdl/cmd_if.sv
hdl/wb_cmd_port.sv
hdl/cmd_fifo.sv
hdl/lane_unit.sv
hdl/vector_unit.sv
hdl/vector_unit_top.sv
dv/tb_vector_unit.sv
